//--- all.f
+incdir+hdl
hdl/booth_pkg.sv
hdl/operand_latch.sv
hdl/booth_core.sv
hdl/product_buffer.sv
hdl/booth_multiplier.sv
verif/booth_assert.sv
verif/booth_tb.sv

//--- Bender.yml
package:
  name: booth_multiplier

export_include_dirs:
  - hdl

sources:
  # RTL
  - include_dirs:
      - hdl
    files:
      - hdl/booth_pkg.sv
      - hdl/operand_latch.sv
      - hdl/booth_core.sv
      - hdl/product_buffer.sv
      - hdl/booth_multiplier.sv

  # verification
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/booth_assert.sv
      - verif/booth_tb.sv

//--- verif/booth_tb.sv
`timescale 1ns/1ps

`include "booth_params.svh"

module booth_tb;

  import booth_pkg::*;

  // pairs sent over all tests: random, corner, back-pressure, blocked, reset
  localparam int total_ops      = 200 + 25 + 150 + 3 + 6 + 20;
  localparam int timeout_cycles = total_ops * (`BOOTH_WIDTH + 2) * 4 + 1000;

  logic     clock;
  logic     reset;
  logic     in_valid;
  logic     in_ready;
  operand_t in_a;
  operand_t in_b;
  logic     out_valid;
  logic     out_ready;
  product_t out_product;

  int seed = 70;
  // 0 always ready, 1 ready about 30%, 2 never ready
  int ready_mode = 0;

  // expected products, oldest first
  product_t exp_q[$];
  product_t expected_product;
  int       accepted_count = 0;
  int       result_count = 0;
  int       error_count = 0;

  booth_multiplier DUT (
    .clock       (clock),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_a        (in_a),
    .in_b        (in_b),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_product (out_product)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function int rand_percent();
    return $unsigned($random(seed)) % 100;
  endfunction

  // most negative, -1, 0, 1, most positive
  function operand_t corner_value(input int idx);
    case (idx)
      0:       return {1'b1, {(`BOOTH_WIDTH-1){1'b0}}};
      1:       return '1;
      2:       return '0;
      3:       return operand_t'(1);
      default: return {1'b0, {(`BOOTH_WIDTH-1){1'b1}}};
    endcase
  endfunction

  // mostly random, with corner values mixed in
  function operand_t pick_operand();
    if (rand_percent() < 15) begin
      return corner_value(rand_percent() % 5);
    end
    return operand_t'({$random(seed), $random(seed)});
  endfunction

  // full signed product of two's-complement operands
  function product_t model_product(input operand_t a, input operand_t b);
    product_t ext_a;
    product_t ext_b;
    ext_a = {{`BOOTH_WIDTH{a[`BOOTH_WIDTH-1]}}, a};
    ext_b = {{`BOOTH_WIDTH{b[`BOOTH_WIDTH-1]}}, b};
    return ext_a * ext_b;
  endfunction

  // output ready pattern, changed on the falling edge
  initial begin
    out_ready = 1'b1;
    forever begin
      @(negedge clock);
      case (ready_mode)
        0:       out_ready = 1'b1;
        1:       out_ready = (rand_percent() < 30);
        default: out_ready = 1'b0;
      endcase
    end
  end

  // scoreboard, sampled on the rising edge
  always @(posedge clock) begin
    if (!reset) begin
      if (in_valid && in_ready) begin
        exp_q.push_back(model_product(in_a, in_b));
        accepted_count++;
      end
      if (out_valid && out_ready) begin
        result_count++;
        assert (exp_q.size() > 0) else begin
          $display("a product came out with no accepted operand pair pending");
          error_count++;
        end
        if (exp_q.size() > 0) begin
          expected_product = exp_q.pop_front();
          assert (out_product === expected_product) else begin
            $display("[ERROR] out_product expected %h actual %h",
                     expected_product, out_product);
            error_count++;
          end
        end
      end
    end
  end

  // offer one pair, idling at random, until it is accepted
  task send_pair(input operand_t a, input operand_t b);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      if (rand_percent() < 60) begin
        in_valid = 1'b1;
        in_a     = a;
        in_b     = b;
        // in_ready only depends on registers, settled since the rising edge
        done     = in_ready;
      end else begin
        in_valid = 1'b0;
        in_a     = pick_operand();
        in_b     = pick_operand();
      end
    end
  endtask

  // stop offering and let every pending product out
  task drain_results();
    @(negedge clock);
    in_valid   = 1'b0;
    ready_mode = 0;
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (4) @(negedge clock);
  endtask

  task report_test(input string name, input int acc0, input int res0);
    assert ((result_count - res0) == (accepted_count - acc0)) else begin
      $display("test %s: %0d results do not match %0d accepted pairs",
               name, result_count - res0, accepted_count - acc0);
      error_count++;
    end
    $display("test %s done: %0d accepted, %0d results, %0d errors so far",
             name, accepted_count - acc0, result_count - res0, error_count);
  endtask

  task random_test();
    int acc0;
    int res0;
    acc0 = accepted_count;
    res0 = result_count;
    ready_mode = 0;
    repeat (200) send_pair(pick_operand(), pick_operand());
    drain_results();
    report_test("random operands", acc0, res0);
  endtask

  task corner_test();
    int acc0;
    int res0;
    acc0 = accepted_count;
    res0 = result_count;
    ready_mode = 0;
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_pair(corner_value(i), corner_value(j));
      end
    end
    drain_results();
    report_test("corner operands", acc0, res0);
  endtask

  task backpressure_test();
    int acc0;
    int res0;
    acc0 = accepted_count;
    res0 = result_count;
    ready_mode = 1;
    repeat (150) send_pair(pick_operand(), pick_operand());
    drain_results();
    report_test("output back-pressure", acc0, res0);
  endtask

  task blocked_input_test();
    int acc0;
    int res0;
    acc0 = accepted_count;
    res0 = result_count;
    // fill latch, core and buffer
    ready_mode = 2;
    repeat (3) send_pair(pick_operand(), pick_operand());
    repeat (40) begin
      @(negedge clock);
      // all three stages full, so no pair may get in
      assert (in_ready === 1'b0) else begin
        $display("[ERROR] in_ready expected %h actual %h", 1'b0, in_ready);
        error_count++;
      end
      in_valid = (rand_percent() < 60);
      in_a     = pick_operand();
      in_b     = pick_operand();
    end
    drain_results();
    report_test("input ignored while not ready", acc0, res0);
  endtask

  task reset_test();
    int acc0;
    int res0;
    ready_mode = 1;
    repeat (6) send_pair(pick_operand(), pick_operand());
    // products still in flight here
    @(negedge clock);
    in_valid = 1'b0;
    reset    = 1'b1;
    exp_q.delete();
    repeat (3) @(negedge clock);
    reset = 1'b0;
    assert (out_valid === 1'b0) else begin
      $display("[ERROR] out_valid expected %h actual %h", 1'b0, out_valid);
      error_count++;
    end
    assert (in_ready === 1'b1) else begin
      $display("[ERROR] in_ready expected %h actual %h", 1'b1, in_ready);
      error_count++;
    end
    acc0 = accepted_count;
    res0 = result_count;
    ready_mode = 0;
    repeat (20) send_pair(pick_operand(), pick_operand());
    drain_results();
    report_test("reset mid-stream", acc0, res0);
  endtask

  // watchdog
  initial begin
    #(timeout_cycles * 100);
    $display("timeout: the run did not end within %0d clock cycles", timeout_cycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    reset    = 1'b1;
    in_valid = 1'b0;
    in_a     = '0;
    in_b     = '0;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    random_test();
    corner_test();
    backpressure_test();
    blocked_input_test();
    reset_test();
    // failures of the bound handshake checks count too
    error_count += DUT.u_assert.fail_count;
    $display("totals: %0d accepted, %0d results, %0d errors",
             accepted_count, result_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verif/booth_assert.sv
`timescale 1ns/1ps

module booth_assert (
  input logic                clock,
  input logic                reset,
  input logic                in_ready,
  input logic                out_valid,
  input logic                out_ready,
  input booth_pkg::product_t out_product
);

  // failed assertions so far, read by the testbench at the end
  int fail_count = 0;

  // stalled output must hold both flag and payload
  property out_held_p;
    @(posedge clock) disable iff (reset)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_product));
  endproperty

  // output side comes out of reset empty
  property out_empty_after_reset_p;
    @(posedge clock) reset |=> !out_valid;
  endproperty

  // input side comes out of reset ready
  property in_ready_after_reset_p;
    @(posedge clock) reset |=> in_ready;
  endproperty

  assert property (out_held_p) else begin
    fail_count++;
    $error("out_valid or out_product changed while out_ready was low");
  end

  assert property (out_empty_after_reset_p) else begin
    fail_count++;
    $error("out_valid was high in the cycle after reset");
  end

  assert property (in_ready_after_reset_p) else begin
    fail_count++;
    $error("in_ready was low in the cycle after reset");
  end

endmodule

// attach to every instance of the top level
bind booth_multiplier booth_assert u_assert (
  .clock       (clock),
  .reset       (reset),
  .in_ready    (in_ready),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_product (out_product)
);

//--- hdl/booth_multiplier.sv
`timescale 1ns/1ps

module booth_multiplier (
  input  logic                clock,
  input  logic                reset,
  // operand side
  input  logic                in_valid,
  output logic                in_ready,
  input  booth_pkg::operand_t in_a,
  input  booth_pkg::operand_t in_b,
  // product side
  output logic                out_valid,
  input  logic                out_ready,
  output booth_pkg::product_t out_product
);

  import booth_pkg::*;

  // latch to core
  logic     op_valid;
  logic     op_take;
  operand_t op_a;
  operand_t op_b;

  // core to buffer
  logic     prod_valid;
  logic     prod_ready;
  product_t prod;

  // input side
  operand_latch u_latch (
    .clock    (clock),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_a     (in_a),
    .in_b     (in_b),
    .op_valid (op_valid),
    .op_a     (op_a),
    .op_b     (op_b),
    .op_take  (op_take)
  );

  // iterative booth core
  booth_core u_core (
    .clock      (clock),
    .reset      (reset),
    .op_valid   (op_valid),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_take    (op_take),
    .prod_valid (prod_valid),
    .prod       (prod),
    .prod_ready (prod_ready)
  );

  // output side
  product_buffer u_buffer (
    .clock       (clock),
    .reset       (reset),
    .prod_valid  (prod_valid),
    .prod        (prod),
    .prod_ready  (prod_ready),
    .out_valid   (out_valid),
    .out_product (out_product),
    .out_ready   (out_ready)
  );

endmodule

//--- hdl/product_buffer.sv
`timescale 1ns/1ps

module product_buffer (
  input  logic                clock,
  input  logic                reset,
  // from the core
  input  logic                prod_valid,
  input  booth_pkg::product_t prod,
  output logic                prod_ready,
  // external output handshake
  output logic                out_valid,
  output booth_pkg::product_t out_product,
  input  logic                out_ready
);

  import booth_pkg::*;

  // one-entry output register
  logic     full_q;
  product_t prod_q;
  logic     capture;

  // slot is free, or is emptied on this edge
  assign prod_ready = !full_q || out_ready;
  assign capture    = prod_valid && prod_ready;

  // full flag
  // capture wins, so drain and refill on one edge stays full
  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (capture) begin
      full_q <= 1'b1;
    end else if (out_ready) begin
      full_q <= 1'b0;
    end
  end

  // product payload
  // only written on capture, held steady otherwise
  always_ff @(posedge clock) begin
    if (capture) begin
      prod_q <= prod;
    end
  end

  assign out_valid   = full_q;
  assign out_product = prod_q;

endmodule

//--- hdl/booth_core.sv
`timescale 1ns/1ps

`include "booth_params.svh"

module booth_core (
  input  logic                clock,
  input  logic                reset,
  // from the operand latch
  input  logic                op_valid,
  input  booth_pkg::operand_t op_a,
  input  booth_pkg::operand_t op_b,
  output logic                op_take,
  // towards the product buffer
  output logic                prod_valid,
  output booth_pkg::product_t prod,
  input  logic                prod_ready
);

  import booth_pkg::*;

  // control
  core_state_e state_q;
  iter_cnt_t   cnt_q;
  logic        last_iter;

  // datapath
  // accumulator is one bit wider than an operand so that
  // subtracting the most negative multiplicand cannot overflow
  operand_t                     mcand_q;
  logic signed [`BOOTH_WIDTH:0] acc_q;
  operand_t                     mplr_q;
  logic                         booth_bit_q;

  logic signed [`BOOTH_WIDTH:0] mcand_ext;
  logic signed [`BOOTH_WIDTH:0] acc_sum;

  // load the pair the moment it is seen in idle
  assign op_take = (state_q == core_idle) && op_valid;

  // final step is the one with count BOOTH_WIDTH-1
  assign last_iter = (cnt_q == iter_cnt_t'(`BOOTH_WIDTH - 1));

  // sign extend multiplicand to accumulator width
  assign mcand_ext = {mcand_q[`BOOTH_WIDTH-1], mcand_q};

  // radix-2 recoding on {q0, q-1}
  always_comb begin
    case ({mplr_q[0], booth_bit_q})
      // start of a run of ones
      2'b10:   acc_sum = acc_q - mcand_ext;
      // end of a run of ones
      2'b01:   acc_sum = acc_q + mcand_ext;
      // inside a run, nothing to add
      default: acc_sum = acc_q;
    endcase
  end

  // FSM and iteration counter
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= core_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        core_idle: begin
          if (op_valid) begin
            state_q <= core_run;
            cnt_q   <= '0;
          end
        end
        core_run: begin
          // one add/sub-and-shift per cycle
          cnt_q <= cnt_q + iter_cnt_t'(1);
          if (last_iter) begin
            state_q <= core_done;
          end
        end
        core_done: begin
          // wait here until the buffer takes the product
          if (prod_ready) begin
            state_q <= core_idle;
          end
        end
        default: begin
          state_q <= core_idle;
        end
      endcase
    end
  end

  // shift register {acc, mplr, booth_bit}
  always_ff @(posedge clock) begin
    if (op_take) begin
      mcand_q     <= op_a;
      acc_q       <= '0;
      mplr_q      <= op_b;
      booth_bit_q <= 1'b0;
    end else if (state_q == core_run) begin
      // arithmetic shift right of the whole register
      acc_q       <= {acc_sum[`BOOTH_WIDTH], acc_sum[`BOOTH_WIDTH:1]};
      mplr_q      <= {acc_sum[0], mplr_q[`BOOTH_WIDTH-1:1]};
      booth_bit_q <= mplr_q[0];
    end
  end

  // product sits in the low 2*W bits once all steps are done
  // the extra accumulator bit is only a guard bit by then
  assign prod_valid = (state_q == core_done);
  assign prod       = {acc_q[`BOOTH_WIDTH-1:0], mplr_q};

endmodule

//--- hdl/operand_latch.sv
`timescale 1ns/1ps

module operand_latch (
  input  logic              clock,
  input  logic              reset,
  // external input handshake
  input  logic              in_valid,
  output logic              in_ready,
  input  booth_pkg::operand_t in_a,
  input  booth_pkg::operand_t in_b,
  // towards the core
  output logic              op_valid,
  output booth_pkg::operand_t op_a,
  output booth_pkg::operand_t op_b,
  input  logic              op_take
);

  import booth_pkg::*;

  // one-entry holding register
  logic     full_q;
  operand_t a_q;
  operand_t b_q;
  logic     accept;

  // empty, or being emptied by the core on this edge
  assign in_ready = !full_q || op_take;
  assign accept   = in_valid && in_ready;

  // full flag
  // a new pair wins over the take, so refill on the same edge keeps it set
  always_ff @(posedge clock) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (op_take) begin
      full_q <= 1'b0;
    end
  end

  // operand pair, only written on an accepted transfer
  always_ff @(posedge clock) begin
    if (accept) begin
      a_q <= in_a;
      b_q <= in_b;
    end
  end

  assign op_valid = full_q;
  assign op_a     = a_q;
  assign op_b     = b_q;

endmodule

//--- hdl/booth_pkg.sv
`include "booth_params.svh"

package booth_pkg;

  // one signed operand
  typedef logic signed [`BOOTH_WIDTH-1:0] operand_t;

  // full signed product, twice the operand width
  typedef logic signed [2*`BOOTH_WIDTH-1:0] product_t;

  // counts the add/subtract-and-shift steps
  typedef logic [`BOOTH_CNT_WIDTH-1:0] iter_cnt_t;

  // core FSM states
  typedef enum logic [1:0] {
    core_idle,
    core_run,
    core_done
  } core_state_e;

endpackage

//--- hdl/booth_params.svh
`ifndef BOOTH_PARAMS_SVH
`define BOOTH_PARAMS_SVH

// operand width in bits
// must be even and at least 4
`define BOOTH_WIDTH 32

// iteration counter width
// wide enough to hold BOOTH_WIDTH
`define BOOTH_CNT_WIDTH 6

`endif
